// File: Makefile
VERILATOR  := verilator
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0
TOP        := cache_tb
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Result: FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# a crash or assertion stop also counts as a failure
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: cache/cache_lookup.sv
// reset clears valids and pointers only; tags are garbage until their way is allocated
`default_nettype none

module cache_lookup
	import cache_geometry_pkg::*;
	import cache_types_pkg::*;
#(
	parameter int NUM_SETS = cache_geometry_pkg::NUM_SETS,
	parameter int NUM_WAYS = cache_geometry_pkg::NUM_WAYS,
	parameter int TAG_BITS = cache_geometry_pkg::TAG_BITS
) (
	input  logic     clock,
	input  logic     reset,
	lookup_if.lookup lk,
	line_if.lookup   ln
);

	localparam int WAY_BITS = $clog2(NUM_WAYS);

	// tag store, one tag per way
	logic [NUM_SETS-1:0][NUM_WAYS-1:0][TAG_BITS-1:0] tags;
	logic [NUM_SETS-1:0][NUM_WAYS-1:0]               valids;
	// per-set round-robin victim
	logic [NUM_SETS-1:0][WAY_BITS-1:0]               rr_ptr;

	// read port match
	logic [NUM_WAYS-1:0] rd_hits;
	logic [WAY_BITS-1:0] rd_way;
	logic                rd_hit;

	// write port match
	logic [NUM_WAYS-1:0] wr_hits;
	logic [WAY_BITS-1:0] wr_hit_way;
	logic                wr_hit;

	// decision for this cycle
	write_kind_e         wr_kind;
	logic [WAY_BITS-1:0] wr_way;
	logic [WAY_BITS-1:0] victim;

	// read CAM on the read set
	tag_cam #(
		.NUM_WAYS (NUM_WAYS),
		.TAG_BITS (TAG_BITS)
	) u_rd_cam (
		.set_tags   (tags[lk.rd_set]),
		.set_valids (valids[lk.rd_set]),
		.tag        (lk.rd_tag),
		.hits       (rd_hits)
	);

	way_encoder #(
		.NUM_WAYS (NUM_WAYS)
	) u_rd_enc (
		.hits    (rd_hits),
		.way     (rd_way),
		.any_hit (rd_hit)
	);

	// write CAM, separate so both ports look up in parallel
	tag_cam #(
		.NUM_WAYS (NUM_WAYS),
		.TAG_BITS (TAG_BITS)
	) u_wr_cam (
		.set_tags   (tags[lk.wr_set]),
		.set_valids (valids[lk.wr_set]),
		.tag        (lk.wr_tag),
		.hits       (wr_hits)
	);

	way_encoder #(
		.NUM_WAYS (NUM_WAYS)
	) u_wr_enc (
		.hits    (wr_hits),
		.way     (wr_hit_way),
		.any_hit (wr_hit)
	);

	assign victim = rr_ptr[lk.wr_set];

	// update on a tag hit, else replace the victim
	always_comb begin
		if (!lk.wr_active) begin
			wr_kind = WR_NONE;
			wr_way  = victim;
		end else if (wr_hit) begin
			wr_kind = WR_UPDATE;
			wr_way  = wr_hit_way;
		end else begin
			wr_kind = WR_ALLOCATE;
			wr_way  = victim;
		end
	end

	// to result
	assign ln.wr_kind = wr_kind;
	assign ln.wr_set  = lk.wr_set;
	assign ln.wr_way  = wr_way;
	assign ln.rd_set  = lk.rd_set;
	assign ln.rd_way  = rd_way;
	assign ln.rd_hit  = rd_hit;

	// valid bits and victim pointers
	always_ff @(posedge clock) begin
		if (reset) begin
			valids <= '0;
			rr_ptr <= '0;
		end else begin
			if (wr_kind != WR_NONE)
				valids[lk.wr_set][wr_way] <= 1'b1;
			// pointer only moves on a miss, wraps at NUM_WAYS
			if (wr_kind == WR_ALLOCATE) begin
				if (victim == WAY_BITS'(NUM_WAYS - 1))
					rr_ptr[lk.wr_set] <= '0;
				else
					rr_ptr[lk.wr_set] <= victim + 1'b1;
			end
		end
	end

	// an update already holds the same tag
	always_ff @(posedge clock) begin
		if (wr_kind == WR_ALLOCATE)
			tags[lk.wr_set][wr_way] <= lk.wr_tag;
	end

endmodule

`default_nettype wire

// File: cache/tag_cam.sv
// one set at a time; an invalid way never reports a hit, whatever its stale tag
`default_nettype none

module tag_cam
	import cache_geometry_pkg::*;
#(
	parameter int NUM_WAYS = cache_geometry_pkg::NUM_WAYS,
	parameter int TAG_BITS = cache_geometry_pkg::TAG_BITS
) (
	input  logic [NUM_WAYS-1:0][TAG_BITS-1:0] set_tags,
	input  logic [NUM_WAYS-1:0]               set_valids,
	input  logic [TAG_BITS-1:0]               tag,
	output logic [NUM_WAYS-1:0]               hits
);

	// all ways compared in parallel
	always_comb begin
		for (int i = 0; i < NUM_WAYS; i++) begin
			// valid mask hides tags left over from before reset
			hits[i] = set_valids[i] && (set_tags[i] == tag);
		end
	end

endmodule

`default_nettype wire

// File: cache/way_encoder.sv
// priority to the lowest way; with a one-hot input that is simply the hit way
`default_nettype none

module way_encoder
	import cache_geometry_pkg::*;
#(
	parameter int NUM_WAYS = cache_geometry_pkg::NUM_WAYS,
	localparam int WAY_BITS = $clog2(NUM_WAYS)
) (
	input  logic [NUM_WAYS-1:0] hits,
	output logic [WAY_BITS-1:0] way,
	output logic                any_hit
);

	// scan from the top so the lowest set bit wins
	always_comb begin
		way = '0;
		for (int i = NUM_WAYS - 1; i >= 0; i--) begin
			if (hits[i])
				way = WAY_BITS'(i);
		end
	end

	// way is 0 when nothing hits, so check this flag first
	assign any_hit = |hits;

endmodule

`default_nettype wire

// File: common/cache_geometry_pkg.sv
// default cache geometry; NUM_SETS and NUM_WAYS must be powers of two and at least 2
`default_nettype none

package cache_geometry_pkg;

	// number of sets in the cache
	localparam int NUM_SETS = 8;

	// ways per set, 32 lines in total with the default sets
	localparam int NUM_WAYS = 4;

	// tag width, upper part of a line address
	localparam int TAG_BITS = 10;

	// one cache line of data
	localparam int DATA_BITS = 64;

	// set index, lower part of a line address
	localparam int SET_BITS = $clog2(NUM_SETS);

	// way number inside a set
	localparam int WAY_BITS = $clog2(NUM_WAYS);

	// full line address as seen on the ports
	localparam int ADDR_BITS = TAG_BITS + SET_BITS;

endpackage

`default_nettype wire

// File: common/cache_ifs.sv
// decode-to-lookup and lookup-to-result buses; widths follow the parameters of the instance
`default_nettype none

// split addresses and bypass, driven by decode
interface lookup_if
	import cache_geometry_pkg::*;
#(
	parameter int NUM_SETS = cache_geometry_pkg::NUM_SETS,
	parameter int TAG_BITS = cache_geometry_pkg::TAG_BITS
);
	localparam int SET_BITS = $clog2(NUM_SETS);

	logic [SET_BITS-1:0] rd_set;
	logic [TAG_BITS-1:0] rd_tag;
	logic                wr_active;
	logic [SET_BITS-1:0] wr_set;
	logic [TAG_BITS-1:0] wr_tag;
	// same line written and read this cycle
	logic                bypass;

	modport decode (output rd_set, rd_tag, wr_active, wr_set, wr_tag, bypass);
	modport lookup (input rd_set, rd_tag, wr_active, wr_set, wr_tag);
	// result only needs to know when to forward wr_data
	modport result (input bypass);
endinterface

// write decision and read hit, driven by lookup
interface line_if
	import cache_geometry_pkg::*;
	import cache_types_pkg::*;
#(
	parameter int NUM_SETS = cache_geometry_pkg::NUM_SETS,
	parameter int NUM_WAYS = cache_geometry_pkg::NUM_WAYS
);
	localparam int SET_BITS = $clog2(NUM_SETS);
	localparam int WAY_BITS = $clog2(NUM_WAYS);

	write_kind_e         wr_kind;
	logic [SET_BITS-1:0] wr_set;
	logic [WAY_BITS-1:0] wr_way;
	logic [SET_BITS-1:0] rd_set;
	logic [WAY_BITS-1:0] rd_way;
	logic                rd_hit;

	modport lookup (output wr_kind, wr_set, wr_way, rd_set, rd_way, rd_hit);
	modport result (input wr_kind, wr_set, wr_way, rd_set, rd_way, rd_hit);
endinterface

`default_nettype wire

// File: common/cache_types_pkg.sv
// write classification shared by lookup and result; two-bit encoding, one value spare
`default_nettype none

package cache_types_pkg;

	// what the write port does in the current cycle
	// WR_NONE     no write strobe
	// WR_UPDATE   tag already present, overwrite that way
	// WR_ALLOCATE tag missed, replace the round-robin victim
	typedef enum logic [1:0] {
		WR_NONE     = 2'd0,
		WR_UPDATE   = 2'd1,
		WR_ALLOCATE = 2'd2
	} write_kind_e;

	// encoding 2'd3 never produced

endpackage

`default_nettype wire

// File: dv/cache_properties.sv
// bound into every cache_lookup; hit checks pause while reset is high
`default_nettype none

module cache_properties
	import cache_geometry_pkg::*;
	import cache_types_pkg::*;
#(
	parameter int NUM_SETS = cache_geometry_pkg::NUM_SETS,
	parameter int NUM_WAYS = cache_geometry_pkg::NUM_WAYS
) (
	input logic                         clock,
	input logic                         reset,
	input logic [NUM_WAYS-1:0]          rd_hits,
	input logic [NUM_WAYS-1:0]          wr_hits,
	input logic                         wr_active,
	input write_kind_e                  wr_kind,
	input logic [NUM_SETS*NUM_WAYS-1:0] valids
);

	// a tag lives in at most one valid way of its set
	rd_hits_onehot: assert property (@(posedge clock) disable iff (reset) $onehot0(rd_hits))
		else $error("read CAM reports more than one hit way");

	wr_hits_onehot: assert property (@(posedge clock) disable iff (reset) $onehot0(wr_hits))
		else $error("write CAM reports more than one hit way");

	// without a strobe the write port stays idle and no line changes state
	idle_no_write: assert property (@(posedge clock) disable iff (reset)
		!wr_active |=> $stable(valids))
		else $error("valid bits changed while the write strobe is low");

	// all lines empty right after a reset edge
	valids_cleared: assert property (@(posedge clock) reset |=> (valids == '0))
		else $error("valid bits not cleared after reset");

endmodule

bind cache_lookup cache_properties #(
	.NUM_SETS (NUM_SETS),
	.NUM_WAYS (NUM_WAYS)
) u_props (
	.clock     (clock),
	.reset     (reset),
	.rd_hits   (rd_hits),
	.wr_hits   (wr_hits),
	.wr_active (lk.wr_active),
	.wr_kind   (wr_kind),
	.valids    (valids)
);

`default_nettype wire

// File: dv/cache_tb.sv
// default geometry only; outputs are sampled 90 units after the edge that drives the inputs
`default_nettype none

module cache_tb
	import cache_geometry_pkg::*;
();

	localparam int RESET_CYCLES = 5;
	localparam int RANDOM_OPS   = 200;

	// line patterns for the directed entries
	localparam logic [DATA_BITS-1:0] DATA_A = 64'h0123_4567_89ab_cdef;
	localparam logic [DATA_BITS-1:0] DATA_B = 64'hfeed_face_cafe_beef;
	localparam logic [DATA_BITS-1:0] DATA_C = 64'h1111_2222_3333_4444;
	localparam logic [DATA_BITS-1:0] DATA_D = 64'h5555_6666_7777_8888;
	localparam logic [DATA_BITS-1:0] DATA_E = 64'h0bad_f00d_dead_c0de;
	localparam logic [DATA_BITS-1:0] DATA_F = 64'ha5a5_5a5a_0f0f_f0f0;
	localparam logic [DATA_BITS-1:0] DATA_G = 64'h7e57_0001_0002_0003;
	localparam logic [DATA_BITS-1:0] NO_DATA = 64'h0;

	// one cycle of stimulus and its expected read result
	typedef struct {
		logic                 wr_en;
		logic [ADDR_BITS-1:0] wr_addr;
		logic [DATA_BITS-1:0] wr_data;
		logic [ADDR_BITS-1:0] rd_addr;
		logic                 exp_valid;
		logic [DATA_BITS-1:0] exp_data;
	} step_t;

	logic                 clock;
	logic                 reset;
	logic                 wr_en;
	logic [ADDR_BITS-1:0] wr_addr;
	logic [DATA_BITS-1:0] wr_data;
	logic [ADDR_BITS-1:0] rd_addr;
	logic [DATA_BITS-1:0] rd_data;
	logic                 rd_valid;

	step_t  steps[$];
	int     cycle_count;
	int     cycle_limit;
	int     pass_count;
	int     fail_count;
	int     errors;
	integer seed;

	// reference model, one entry per set and way
	logic [TAG_BITS-1:0]  m_tag   [NUM_SETS][NUM_WAYS];
	logic                 m_valid [NUM_SETS][NUM_WAYS];
	logic [DATA_BITS-1:0] m_data  [NUM_SETS][NUM_WAYS];
	int                   m_ptr   [NUM_SETS];

	cache_top UUT (
		.clock    (clock),
		.reset    (reset),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.rd_valid (rd_valid)
	);

	always #50 clock = ~clock;

	// watchdog
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Result: FAILED");
			$finish;
		end
	end

	// tag above set index
	function automatic logic [ADDR_BITS-1:0] line_addr(input int tag, input int set);
		line_addr = {tag[TAG_BITS-1:0], set[SET_BITS-1:0]};
	endfunction

	task automatic add_step(input logic we, input int wtag, input int wset,
			input logic [DATA_BITS-1:0] wd, input int rtag, input int rset,
			input logic ev, input logic [DATA_BITS-1:0] ed);
		step_t s;
		s.wr_en     = we;
		s.wr_addr   = line_addr(wtag, wset);
		s.wr_data   = wd;
		s.rd_addr   = line_addr(rtag, rset);
		s.exp_valid = ev;
		s.exp_data  = ed;
		steps.push_back(s);
	endtask

	task automatic build_table();
		// empty after reset
		add_step(1'b0, 0, 0, NO_DATA, 0, 0, 1'b0, NO_DATA);
		add_step(1'b0, 0, 0, NO_DATA, 1023, 7, 1'b0, NO_DATA);
		add_step(1'b0, 0, 0, NO_DATA, 5, 3, 1'b0, NO_DATA);
		// write then read, other tag and other set miss
		add_step(1'b1, 1, 2, DATA_A, 0, 0, 1'b0, NO_DATA);
		add_step(1'b0, 0, 0, NO_DATA, 1, 2, 1'b1, DATA_A);
		add_step(1'b0, 0, 0, NO_DATA, 2, 2, 1'b0, NO_DATA);
		add_step(1'b0, 0, 0, NO_DATA, 1, 3, 1'b0, NO_DATA);
		// same line forwarded, other line of the set stays old
		add_step(1'b1, 3, 2, DATA_B, 3, 2, 1'b1, DATA_B);
		add_step(1'b0, 0, 0, NO_DATA, 3, 2, 1'b1, DATA_B);
		add_step(1'b1, 4, 2, DATA_C, 1, 2, 1'b1, DATA_A);
		add_step(1'b1, 5, 2, DATA_D, 4, 2, 1'b1, DATA_C);
		// set 2 full, update tag 3 in place
		add_step(1'b1, 3, 2, DATA_E, 5, 2, 1'b1, DATA_D);
		add_step(1'b0, 0, 0, NO_DATA, 3, 2, 1'b1, DATA_E);
		add_step(1'b0, 0, 0, NO_DATA, 1, 2, 1'b1, DATA_A);
		add_step(1'b0, 0, 0, NO_DATA, 4, 2, 1'b1, DATA_C);
		add_step(1'b0, 0, 0, NO_DATA, 5, 2, 1'b1, DATA_D);
		// fifth tag evicts tag 1 only if the update left the pointer alone
		add_step(1'b1, 6, 2, DATA_F, 1, 2, 1'b1, DATA_A);
		add_step(1'b0, 0, 0, NO_DATA, 1, 2, 1'b0, NO_DATA);
		add_step(1'b0, 0, 0, NO_DATA, 3, 2, 1'b1, DATA_E);
		add_step(1'b0, 0, 0, NO_DATA, 4, 2, 1'b1, DATA_C);
		add_step(1'b0, 0, 0, NO_DATA, 5, 2, 1'b1, DATA_D);
		add_step(1'b0, 0, 0, NO_DATA, 6, 2, 1'b1, DATA_F);
		// forwarding on an update too
		add_step(1'b1, 4, 2, DATA_G, 4, 2, 1'b1, DATA_G);
		add_step(1'b0, 0, 0, NO_DATA, 4, 2, 1'b1, DATA_G);
	endtask

	task automatic model_reset();
		for (int s = 0; s < NUM_SETS; s++) begin
			m_ptr[s] = 0;
			for (int w = 0; w < NUM_WAYS; w++)
				m_valid[s][w] = 1'b0;
		end
	endtask

	// expected read result before this cycle's write lands
	task automatic model_read(input logic we, input logic [ADDR_BITS-1:0] wa,
			input logic [DATA_BITS-1:0] wd, input logic [ADDR_BITS-1:0] ra,
			output logic ev, output logic [DATA_BITS-1:0] ed);
		int set;
		set = int'(ra[SET_BITS-1:0]);
		ev  = 1'b0;
		ed  = '0;
		if (we && wa == ra) begin
			ev = 1'b1;
			ed = wd;
		end else begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (m_valid[set][w] && m_tag[set][w] == ra[ADDR_BITS-1:SET_BITS]) begin
					ev = 1'b1;
					ed = m_data[set][w];
				end
			end
		end
	endtask

	// hit overwrites in place, miss takes the round-robin way
	task automatic model_write(input logic [ADDR_BITS-1:0] wa, input logic [DATA_BITS-1:0] wd);
		int set;
		int hit;
		int w;
		set = int'(wa[SET_BITS-1:0]);
		hit = -1;
		for (int i = 0; i < NUM_WAYS; i++) begin
			if (m_valid[set][i] && m_tag[set][i] == wa[ADDR_BITS-1:SET_BITS])
				hit = i;
		end
		if (hit >= 0) begin
			m_data[set][hit] = wd;
		end else begin
			w = m_ptr[set];
			m_tag[set][w]   = wa[ADDR_BITS-1:SET_BITS];
			m_valid[set][w] = 1'b1;
			m_data[set][w]  = wd;
			m_ptr[set]      = (w + 1) % NUM_WAYS;
		end
	endtask

	// inputs change on the edge, outputs read near the end of the cycle
	task automatic apply(input logic we, input logic [ADDR_BITS-1:0] wa,
			input logic [DATA_BITS-1:0] wd, input logic [ADDR_BITS-1:0] ra);
		@(posedge clock);
		wr_en   <= we;
		wr_addr <= wa;
		wr_data <= wd;
		rd_addr <= ra;
		#90;
	endtask

	task automatic check_outputs(input logic ev, input logic [DATA_BITS-1:0] ed);
		assert (rd_valid === ev) else begin
			$display("ERR rd_valid: expected %h, got %h", ev, rd_valid);
			errors++;
		end
		// data is don't-care on a miss
		if (ev) begin
			assert (rd_data === ed) else begin
				$display("ERR rd_data: expected %h, got %h", ed, rd_data);
				errors++;
			end
		end
	endtask

	initial begin
		step_t                s;
		logic                 ev;
		logic [DATA_BITS-1:0] ed;
		logic [31:0]          r;
		logic                 we;
		logic [ADDR_BITS-1:0] wa;
		logic [ADDR_BITS-1:0] ra;
		logic [DATA_BITS-1:0] wd;

		seed    = 4;
		clock   = 1'b0;
		reset   = 1'b1;
		wr_en   = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		rd_addr = '0;
		build_table();
		cycle_limit = RESET_CYCLES + 2 * steps.size() + RANDOM_OPS;
		model_reset();

		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;

		// directed entries, model follows along for the random phase
		foreach (steps[i]) begin
			s      = steps[i];
			errors = 0;
			apply(s.wr_en, s.wr_addr, s.wr_data, s.rd_addr);
			check_outputs(s.exp_valid, s.exp_data);
			if (s.wr_en)
				model_write(s.wr_addr, s.wr_data);
			if (errors == 0)
				pass_count++;
			else
				fail_count++;
			$display("entry %0d: %s", i, (errors == 0) ? "ok" : "mismatch");
		end

		// small tag range so hits and evictions are frequent
		errors = 0;
		for (int n = 0; n < RANDOM_OPS; n++) begin
			r  = $random(seed);
			we = r[0];
			wa = line_addr(int'(r[3:1]), int'(r[6:4]));
			if (r[7])
				ra = wa;
			else
				ra = line_addr(int'(r[10:8]), int'(r[13:11]));
			wd = {$random(seed), $random(seed)};
			apply(we, wa, wd, ra);
			model_read(we, wa, wd, ra, ev, ed);
			check_outputs(ev, ed);
			if (we)
				model_write(wa, wd);
		end
		if (errors == 0)
			pass_count++;
		else
			fail_count++;
		$display("random phase: %0d operations, %0d errors", RANDOM_OPS, errors);

		$display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
common/cache_geometry_pkg.sv
common/cache_types_pkg.sv
common/cache_ifs.sv
cache/tag_cam.sv
cache/way_encoder.sv
verilog/cache_decode.sv
cache/cache_lookup.sv
verilog/cache_result.sv
verilog/cache_top.sv
dv/cache_properties.sv
dv/cache_tb.sv

// File: verilog/cache_decode.sv
// address split is tag above set index; bypass compares full line addresses only
`default_nettype none

module cache_decode
	import cache_geometry_pkg::*;
#(
	parameter int NUM_SETS = cache_geometry_pkg::NUM_SETS,
	parameter int TAG_BITS = cache_geometry_pkg::TAG_BITS,
	localparam int SET_BITS = $clog2(NUM_SETS),
	localparam int ADDR_BITS = TAG_BITS + SET_BITS
) (
	lookup_if.decode lk,

	input  logic                 wr_en,
	input  logic [ADDR_BITS-1:0] wr_addr,
	input  logic [ADDR_BITS-1:0] rd_addr
);

	// read address
	// low bits pick the set, the rest is the tag
	assign lk.rd_set = rd_addr[SET_BITS-1:0];
	assign lk.rd_tag = rd_addr[ADDR_BITS-1:SET_BITS];

	// write address, same split
	assign lk.wr_set = wr_addr[SET_BITS-1:0];
	assign lk.wr_tag = wr_addr[ADDR_BITS-1:SET_BITS];

	// no handshake, the strobe alone starts a write
	assign lk.wr_active = wr_en;

	// same line in both ports this cycle
	// the array still holds the old line, so result must forward wr_data
	// a different line in the same set is not forwarded
	assign lk.bypass = wr_en && (wr_addr == rd_addr);

endmodule

`default_nettype wire

// File: verilog/cache_result.sv
// data array has no reset; rd_data is meaningless whenever rd_valid is low
`default_nettype none

module cache_result
	import cache_geometry_pkg::*;
	import cache_types_pkg::*;
#(
	parameter int NUM_SETS  = cache_geometry_pkg::NUM_SETS,
	parameter int NUM_WAYS  = cache_geometry_pkg::NUM_WAYS,
	parameter int DATA_BITS = cache_geometry_pkg::DATA_BITS
) (
	input  logic                 clock,
	lookup_if.result             lk,
	line_if.result               ln,
	input  logic [DATA_BITS-1:0] wr_data,
	output logic [DATA_BITS-1:0] rd_data,
	output logic                 rd_valid
);

	// one line per set and way
	logic [DATA_BITS-1:0] data [NUM_SETS][NUM_WAYS];

	// update and allocate both store the full line
	// set and way come from lookup
	always_ff @(posedge clock) begin
		if (ln.wr_kind != WR_NONE)
			data[ln.wr_set][ln.wr_way] <= wr_data;
	end

	// read output, purely combinational
	always_comb begin
		if (lk.bypass) begin
			// array not written until the edge, forward the new line
			rd_data  = wr_data;
			rd_valid = 1'b1;
		end else begin
			// other lines of the set still show their old contents
			rd_data  = data[ln.rd_set][ln.rd_way];
			rd_valid = ln.rd_hit;
		end
	end

endmodule

`default_nettype wire

// File: verilog/cache_top.sv
// no miss handling or back-pressure; one read and one write are taken every cycle
`default_nettype none

module cache_top
	import cache_geometry_pkg::*;
#(
	parameter int NUM_SETS  = cache_geometry_pkg::NUM_SETS,
	parameter int NUM_WAYS  = cache_geometry_pkg::NUM_WAYS,
	parameter int TAG_BITS  = cache_geometry_pkg::TAG_BITS,
	parameter int DATA_BITS = cache_geometry_pkg::DATA_BITS,
	localparam int SET_BITS  = $clog2(NUM_SETS),
	localparam int ADDR_BITS = TAG_BITS + SET_BITS
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 wr_en,
	input  logic [ADDR_BITS-1:0] wr_addr,
	input  logic [DATA_BITS-1:0] wr_data,
	input  logic [ADDR_BITS-1:0] rd_addr,
	output logic [DATA_BITS-1:0] rd_data,
	output logic                 rd_valid
);

	// decode to lookup and result
	lookup_if #(
		.NUM_SETS (NUM_SETS),
		.TAG_BITS (TAG_BITS)
	) lk ();

	// lookup to result
	line_if #(
		.NUM_SETS (NUM_SETS),
		.NUM_WAYS (NUM_WAYS)
	) ln ();

	cache_decode #(
		.NUM_SETS (NUM_SETS),
		.TAG_BITS (TAG_BITS)
	) u_decode (
		.lk      (lk.decode),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.rd_addr (rd_addr)
	);

	cache_lookup #(
		.NUM_SETS (NUM_SETS),
		.NUM_WAYS (NUM_WAYS),
		.TAG_BITS (TAG_BITS)
	) u_lookup (
		.clock (clock),
		.reset (reset),
		.lk    (lk.lookup),
		.ln    (ln.lookup)
	);

	// write data skips decode and lookup
	cache_result #(
		.NUM_SETS  (NUM_SETS),
		.NUM_WAYS  (NUM_WAYS),
		.DATA_BITS (DATA_BITS)
	) u_result (
		.clock    (clock),
		.lk       (lk.result),
		.ln       (ln.result),
		.wr_data  (wr_data),
		.rd_data  (rd_data),
		.rd_valid (rd_valid)
	);

endmodule

`default_nettype wire
